//--- list.f
design/pipe_pkg.sv
design/phy_ctl_pkg.sv
design/rx_detect_fsm.sv
design/phy_status_gen.sv
design/rx_valid_qual.sv
design/pcie_phy_ctl.sv
bench/tb_clock.sv
bench/tb_pcie_phy_ctl.sv

//--- run.sh
#!/bin/sh
# Build and run the PIPE control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_pcie_phy_ctl
./obj_dir/Vtb_pcie_phy_ctl > sim.log 2>&1
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0

//--- bench/tb_pcie_phy_ctl.sv
// Random-stimulus testbench for the PIPE control top, checked each cycle against a model
module tb_pcie_phy_ctl;

   localparam logic [31:0] SEED = 32'h98f82d6a;
   // Detect runs, power-state run, lock toggling and three ready phases, with margin
   localparam int TIMEOUT_CYCLES = 30000;
   // Request sampled on one edge, then two register stages
   localparam int REQ_TO_EN = 3;
   // Done sampled on one edge, then four cycles to the enable drop
   localparam int DONE_TO_FALL = 5;
   // Longest wait for any detect output edge
   localparam int WAIT_LIMIT = 2000;

   logic PCLK;
   logic RESET_n;

   // DUT inputs
   pipe_pkg::power_state_t           power_down;
   logic                             tx_detect_rx;
   logic                             tx_elec_idle;
   logic                             phy_l0;
   logic                             pll_lol;
   logic                             pcie_done;
   logic                             pcie_con;
   logic                             pcs_rx_valid;
   logic                             pcs_rx_elec_idle;
   logic                             pcs_rx_lol;
   logic [pipe_pkg::RX_STATUS_W-1:0] pcs_rx_status;
   logic                             rsl_rx_rdy;

   // DUT outputs
   logic                             pcie_det_en;
   logic                             pcie_ct;
   logic                             phy_status;
   logic [pipe_pkg::RX_STATUS_W-1:0] rx_status;
   logic                             rx_valid;
   logic                             rx_lol;
   logic                             pcie_ip_rstn;

   // Reference model state
   logic                              m_plol1;
   logic                              m_plol2;
   pipe_pkg::power_state_t            m_pd_prev;
   logic                              m_done_q;
   logic [2:0]                        m_age;
   logic                              m_con;
   logic                              m_phy;
   logic [pipe_pkg::RX_STATUS_W-1:0]  m_rxs;
   logic                              m_rst1;
   logic                              m_rstn;
   logic                              m_lol1;
   logic                              m_rxlol;
   logic [phy_ctl_pkg::RDY_CNT_W-1:0] m_cnt;
   logic                              m_rxv;
   logic                              m_clean;

   int          errors = 0;
   int          cycle_count = 0;
   logic        in_detect;

   tb_clock i_clock (
      .PCLK    (PCLK),
      .RESET_n (RESET_n)
   );

   pcie_phy_ctl i_dut (
      .PCLK             (PCLK),
      .RESET_n          (RESET_n),
      .power_down       (power_down),
      .tx_detect_rx     (tx_detect_rx),
      .tx_elec_idle     (tx_elec_idle),
      .phy_l0           (phy_l0),
      .pll_lol          (pll_lol),
      .pcie_done        (pcie_done),
      .pcie_con         (pcie_con),
      .pcs_rx_valid     (pcs_rx_valid),
      .pcs_rx_elec_idle (pcs_rx_elec_idle),
      .pcs_rx_lol       (pcs_rx_lol),
      .pcs_rx_status    (pcs_rx_status),
      .rsl_rx_rdy       (rsl_rx_rdy),
      .pcie_det_en      (pcie_det_en),
      .pcie_ct          (pcie_ct),
      .phy_status       (phy_status),
      .rx_status        (rx_status),
      .rx_valid         (rx_valid),
      .rx_lol           (rx_lol),
      .pcie_ip_rstn     (pcie_ip_rstn)
   );

   // ======================================
   // Model helpers
   // ======================================

   // Power-state changes that get a PhyStatus handshake
   function automatic logic legal_change(input pipe_pkg::power_state_t prev,
                                         input pipe_pkg::power_state_t cur);
      legal_change = 1'b0;
      if (prev == pipe_pkg::P0 && cur != pipe_pkg::P0) legal_change = 1'b1;
      if (prev == pipe_pkg::P2 && cur == pipe_pkg::P1) legal_change = 1'b1;
      if (prev == pipe_pkg::P0S && cur == pipe_pkg::P0) legal_change = 1'b1;
      if (prev == pipe_pkg::P1 && cur == pipe_pkg::P0) legal_change = 1'b1;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
   endtask

   // Falling edges until detect enable or charge time reaches a level
   task automatic wait_for_level(input bit use_ct, input logic level, output int cycles);
      cycles = 0;
      do begin
         @(negedge PCLK);
         cycles++;
      end while (((use_ct ? pcie_ct : pcie_det_en) !== level) && cycles < WAIT_LIMIT);
   endtask

   task automatic set_clean_rx();
      rsl_rx_rdy       = 1'b1;
      pcs_rx_valid     = 1'b1;
      pcs_rx_elec_idle = 1'b0;
      pcs_rx_lol       = 1'b0;
      pcs_rx_status    = pipe_pkg::RX_OK;
   endtask

   // One receiver-detect sequence with a given result and PCS done delay
   task automatic run_detect(input logic con, input int done_delay);
      int         cycles;
      logic [2:0] exp_status;
      exp_status = con ? pipe_pkg::RX_DETECTED : pipe_pkg::RX_OK;
      in_detect    = 1'b1;
      power_down   = pipe_pkg::P1;
      tx_detect_rx = 1'b1;
      tx_elec_idle = 1'b1;
      wait_for_level(1'b0, 1'b1, cycles);
      if (cycles != REQ_TO_EN) report_mismatch("pcie_det_en rise delay", 32'(REQ_TO_EN),
                                               32'(cycles));
      tx_detect_rx = 1'b0;
      wait_for_level(1'b1, 1'b1, cycles);
      if (cycles != int'(phy_ctl_pkg::DET_EN_CYCLES)) begin
         report_mismatch("pcie_ct start delay", 32'(phy_ctl_pkg::DET_EN_CYCLES), 32'(cycles));
      end
      wait_for_level(1'b1, 1'b0, cycles);
      if (cycles != int'(phy_ctl_pkg::CT_CYCLES)) begin
         report_mismatch("pcie_ct width", 32'(phy_ctl_pkg::CT_CYCLES), 32'(cycles));
      end
      if (pcie_det_en !== 1'b1) report_mismatch("pcie_det_en", 32'd1, 32'(pcie_det_en));
      repeat (done_delay) @(negedge PCLK);
      pcie_done = 1'b1;
      pcie_con  = con;
      wait_for_level(1'b0, 1'b0, cycles);
      if (cycles != DONE_TO_FALL) report_mismatch("pcie_det_en fall delay",
                                                  32'(DONE_TO_FALL), 32'(cycles));
      // Completion handshake one cycle after the enable drops
      @(negedge PCLK);
      if (phy_status !== 1'b1) report_mismatch("phy_status", 32'd1, 32'(phy_status));
      if (rx_status !== exp_status) report_mismatch("rx_status", 32'(exp_status),
                                                    32'(rx_status));
      pcie_done = 1'b0;
      pcie_con  = 1'b0;
      in_detect = 1'b0;
      // Let the done synchronizer drain
      repeat (8) @(negedge PCLK);
   endtask

   // ======================================
   // Reference model, updated on the rising edge
   // ======================================

   assign m_clean = m_rstn & pcs_rx_valid & ~pcs_rx_elec_idle & ~pcs_rx_lol &
                    (pcs_rx_status == pipe_pkg::RX_OK);

   always @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         m_plol1   <= 1'b1;
         m_plol2   <= 1'b1;
         m_pd_prev <= pipe_pkg::P0;
         m_done_q  <= 1'b0;
         m_age     <= 3'd0;
         m_con     <= 1'b0;
         m_phy     <= 1'b1;
         m_rxs     <= pipe_pkg::RX_OK;
         m_rst1    <= 1'b0;
         m_rstn    <= 1'b0;
         m_lol1    <= 1'b0;
         m_rxlol   <= 1'b0;
         m_cnt     <= '0;
         m_rxv     <= 1'b0;
      end else begin
         m_plol1   <= pll_lol;
         m_plol2   <= m_plol1;
         m_pd_prev <= power_down;
         // Age of the last done rise, completion seen at age five
         m_done_q  <= pcie_done;
         if (pcie_done && !m_done_q) begin
            m_age <= 3'd1;
            m_con <= pcie_con;
         end else if (m_age != 3'd0) begin
            m_age <= (m_age == 3'd5) ? 3'd0 : m_age + 3'd1;
         end
         if (!m_plol2) m_phy <= legal_change(m_pd_prev, power_down) | (m_age == 3'd5);
         if (m_age == 3'd5) begin
            m_rxs <= m_con ? pipe_pkg::RX_DETECTED : pipe_pkg::RX_OK;
         end else begin
            m_rxs <= pcs_rx_status;
         end
         m_rst1  <= rsl_rx_rdy;
         m_rstn  <= m_rst1;
         m_lol1  <= pcs_rx_lol;
         m_rxlol <= m_lol1;
         m_cnt   <= m_clean ? m_cnt + 1'b1 : '0;
         if (phy_l0 && pcs_rx_valid && !pcs_rx_elec_idle && !pcs_rx_lol) begin
            m_rxv <= 1'b1;
         end else if (pcs_rx_valid && m_cnt == phy_ctl_pkg::RDY_COUNT) begin
            m_rxv <= 1'b1;
         end else if (!m_rstn || !pcs_rx_valid || pcs_rx_elec_idle || pcs_rx_lol) begin
            m_rxv <= 1'b0;
         end
      end
   end

   // Outputs compared on the falling edge, where they are settled
   always @(negedge PCLK) begin
      if (phy_status !== m_phy) report_mismatch("phy_status", 32'(m_phy), 32'(phy_status));
      if (rx_status !== m_rxs) report_mismatch("rx_status", 32'(m_rxs), 32'(rx_status));
      if (rx_valid !== m_rxv) report_mismatch("rx_valid", 32'(m_rxv), 32'(rx_valid));
      if (rx_lol !== m_rxlol) report_mismatch("rx_lol", 32'(m_rxlol), 32'(rx_lol));
      if (pcie_ip_rstn !== m_rstn) report_mismatch("pcie_ip_rstn", 32'(m_rstn),
                                                   32'(pcie_ip_rstn));
      if (!in_detect && pcie_det_en !== 1'b0) report_mismatch("pcie_det_en", 32'd0,
                                                              32'(pcie_det_en));
      if (!in_detect && pcie_ct !== 1'b0) report_mismatch("pcie_ct", 32'd0, 32'(pcie_ct));
   end

   always @(posedge PCLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ======================================
   // Stimulus
   // ======================================

   initial begin
      power_down       = pipe_pkg::P0;
      tx_detect_rx     = 1'b0;
      tx_elec_idle     = 1'b0;
      phy_l0           = 1'b0;
      pll_lol          = 1'b1;
      pcie_done        = 1'b0;
      pcie_con         = 1'b0;
      pcs_rx_valid     = 1'b0;
      pcs_rx_elec_idle = 1'b1;
      pcs_rx_lol       = 1'b0;
      pcs_rx_status    = pipe_pkg::RX_OK;
      rsl_rx_rdy       = 1'b0;
      in_detect        = 1'b0;
      void'($urandom(SEED));
      @(posedge RESET_n);
      // PLL still unlocked, PhyStatus held high
      repeat (12) @(negedge PCLK);
      pll_lol    = 1'b0;
      rsl_rx_rdy = 1'b1;
      repeat (8) @(negedge PCLK);
      for (int i = 0; i < 8; i++) begin
         run_detect(($urandom_range(0, 1) == 1), int'($urandom_range(0, 24)));
      end
      // Power-state changes with the PLL locked
      repeat (2000) begin
         @(negedge PCLK);
         if ($urandom_range(0, 2) == 0) begin
            power_down = pipe_pkg::power_state_t'($urandom_range(0, 3));
         end
         pcs_rx_status    = 3'($urandom_range(0, 7));
         pcs_rx_valid     = ($urandom_range(0, 3) != 0);
         pcs_rx_elec_idle = ($urandom_range(0, 7) == 0);
      end
      // PLL lock toggling freezes PhyStatus
      repeat (600) begin
         @(negedge PCLK);
         if ($urandom_range(0, 15) == 0) pll_lol = ~pll_lol;
         if ($urandom_range(0, 2) == 0) begin
            power_down = pipe_pkg::power_state_t'($urandom_range(0, 3));
         end
      end
      @(negedge PCLK);
      pll_lol = 1'b0;
      // Clean receive stretch longer than the ready count
      set_clean_rx();
      repeat (1100) @(negedge PCLK);
      if (rx_valid !== 1'b1) begin
         $display("Error at %0t: rx_valid did not rise during the clean receive stretch",
                  $time);
         errors++;
      end
      // Single-cycle glitches interrupt the count
      repeat (1100) begin
         @(negedge PCLK);
         set_clean_rx();
         case ($urandom_range(0, 1999))
            0: pcs_rx_elec_idle = 1'b1;
            1: pcs_rx_lol = 1'b1;
            2: pcs_rx_status = 3'($urandom_range(1, 7));
            3: pcs_rx_valid = 1'b0;
            4: rsl_rx_rdy = 1'b0;
            default: ;
         endcase
      end
      // L0 fast path with a noisy receiver
      phy_l0 = 1'b1;
      repeat (1100) begin
         @(negedge PCLK);
         pcs_rx_valid     = ($urandom_range(0, 9) != 0);
         pcs_rx_elec_idle = ($urandom_range(0, 19) == 0);
         pcs_rx_lol       = ($urandom_range(0, 19) == 0);
         pcs_rx_status    = ($urandom_range(0, 3) == 0) ? 3'($urandom_range(1, 7)) : 3'd0;
      end
      phy_l0 = 1'b0;
      repeat (4) @(negedge PCLK);
      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- bench/tb_clock.sv
// Clock and power-on reset source for the PIPE control testbench
module tb_clock (
   output logic PCLK,
   output logic RESET_n
);

   // 20 time unit period, starts low
   initial begin
      PCLK = 1'b0;
      forever #10 PCLK = ~PCLK;
   end

   // Reset held for the first four cycles, released on a falling edge
   initial begin
      RESET_n = 1'b0;
      repeat (4) @(negedge PCLK);
      RESET_n = 1'b1;
   end

endmodule

//--- design/pcie_phy_ctl.sv
// Top of the x1 PIPE control logic between the MAC and the vendor PCS
module pcie_phy_ctl (
   input  logic                             PCLK,
   input  logic                             RESET_n,
   // MAC side
   input  pipe_pkg::power_state_t           power_down,
   input  logic                             tx_detect_rx,
   input  logic                             tx_elec_idle,
   input  logic                             phy_l0,
   // PCS side status
   input  logic                             pll_lol,
   input  logic                             pcie_done,
   input  logic                             pcie_con,
   input  logic                             pcs_rx_valid,
   input  logic                             pcs_rx_elec_idle,
   input  logic                             pcs_rx_lol,
   input  logic [pipe_pkg::RX_STATUS_W-1:0] pcs_rx_status,
   input  logic                             rsl_rx_rdy,
   // PCS side control
   output logic                             pcie_det_en,
   output logic                             pcie_ct,
   // MAC side status
   output logic                             phy_status,
   output logic [pipe_pkg::RX_STATUS_W-1:0] rx_status,
   output logic                             rx_valid,
   output logic                             rx_lol,
   output logic                             pcie_ip_rstn
);

   // Detect completion pulse and its result
   logic detect_done;
   logic rx_present;

   // Receiver-detect sequencing
   rx_detect_fsm u_rx_detect_fsm (
      .PCLK         (PCLK),
      .RESET_n      (RESET_n),
      .power_down   (power_down),
      .tx_detect_rx (tx_detect_rx),
      .tx_elec_idle (tx_elec_idle),
      .pcie_done    (pcie_done),
      .pcie_con     (pcie_con),
      .pcie_det_en  (pcie_det_en),
      .pcie_ct      (pcie_ct),
      .detect_done  (detect_done),
      .rx_present   (rx_present)
   );

   // PhyStatus and RxStatus
   phy_status_gen u_phy_status_gen (
      .PCLK          (PCLK),
      .RESET_n       (RESET_n),
      .power_down    (power_down),
      .pll_lol       (pll_lol),
      .detect_done   (detect_done),
      .rx_present    (rx_present),
      .pcs_rx_status (pcs_rx_status),
      .phy_status    (phy_status),
      .rx_status     (rx_status)
   );

   // Core reset and RxValid
   rx_valid_qual u_rx_valid_qual (
      .PCLK             (PCLK),
      .RESET_n          (RESET_n),
      .rsl_rx_rdy       (rsl_rx_rdy),
      .pcs_rx_valid     (pcs_rx_valid),
      .pcs_rx_elec_idle (pcs_rx_elec_idle),
      .pcs_rx_lol       (pcs_rx_lol),
      .pcs_rx_status    (pcs_rx_status),
      .phy_l0           (phy_l0),
      .pcie_ip_rstn     (pcie_ip_rstn),
      .rx_valid         (rx_valid),
      .rx_lol           (rx_lol)
   );

endmodule

//--- design/rx_valid_qual.sv
// Core reset release and RxValid qualification for the single PCIe lane
module rx_valid_qual (
   input  logic                             PCLK,
   input  logic                             RESET_n,
   input  logic                             rsl_rx_rdy,
   input  logic                             pcs_rx_valid,
   input  logic                             pcs_rx_elec_idle,
   input  logic                             pcs_rx_lol,
   input  logic [pipe_pkg::RX_STATUS_W-1:0] pcs_rx_status,
   input  logic                             phy_l0,
   output logic                             pcie_ip_rstn,
   output logic                             rx_valid,
   output logic                             rx_lol
);

   // First synchronizer stages
   logic rstn_meta;
   logic lol_meta;

   // Receive path clean this cycle
   logic rx_clean;

   logic [phy_ctl_pkg::RDY_CNT_W-1:0] rdy_cnt;

   // ======================================
   // Synchronizers
   // ======================================

   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         rstn_meta    <= 1'b0;
         pcie_ip_rstn <= 1'b0;
         lol_meta     <= 1'b0;
         rx_lol       <= 1'b0;
      end else begin
         // Core held in reset until PCS ready crosses
         rstn_meta    <= rsl_rx_rdy;
         pcie_ip_rstn <= rstn_meta;
         lol_meta     <= pcs_rx_lol;
         rx_lol       <= lol_meta;
      end
   end

   // ======================================
   // Ready counter and RxValid
   // ======================================

   assign rx_clean = pcie_ip_rstn & pcs_rx_valid & ~pcs_rx_elec_idle & ~pcs_rx_lol &
                     (pcs_rx_status == pipe_pkg::RX_OK);

   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         rdy_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         // Any disturbance restarts the stable count, wraps when left running
         if (rx_clean) begin
            rdy_cnt <= rdy_cnt + 1'b1;
         end else begin
            rdy_cnt <= '0;
         end
         // Fast path in L0
         if (phy_l0 & pcs_rx_valid & ~pcs_rx_elec_idle & ~pcs_rx_lol) begin
            rx_valid <= 1'b1;
         end else if (pcs_rx_valid & (rdy_cnt == phy_ctl_pkg::RDY_COUNT)) begin
            // Long qualification complete
            rx_valid <= 1'b1;
         end else if (~pcie_ip_rstn | ~pcs_rx_valid | pcs_rx_elec_idle | pcs_rx_lol) begin
            rx_valid <= 1'b0;
         end
      end
   end

   // No RxValid out of core reset outside L0
   // Ready count already cleared once the core reset has been low for a cycle
   a_no_valid_in_rst : assert property (@(posedge PCLK) disable iff (!RESET_n)
      (!pcie_ip_rstn && !$past(pcie_ip_rstn) && !phy_l0) |=> !rx_valid);

endmodule

//--- design/phy_status_gen.sv
// PhyStatus and RxStatus generation toward the MAC, gated by PLL lock
module phy_status_gen (
   input  logic                             PCLK,
   input  logic                             RESET_n,
   input  pipe_pkg::power_state_t           power_down,
   input  logic                             pll_lol,
   input  logic                             detect_done,
   input  logic                             rx_present,
   input  logic [pipe_pkg::RX_STATUS_W-1:0] pcs_rx_status,
   output logic                             phy_status,
   output logic [pipe_pkg::RX_STATUS_W-1:0] rx_status
);

   // PLL lock-loss synchronizer, starts as unlocked
   logic plol_s1;
   logic plol_s2;

   // Previous power state and the legal-change decode
   pipe_pkg::power_state_t pd_prev;
   logic                   pd_legal;

   // ======================================
   // Power state change decode
   // ======================================

   always_comb begin
      case ({pd_prev, power_down})
         {pipe_pkg::P0,  pipe_pkg::P2 }: pd_legal = 1'b1;
         {pipe_pkg::P2,  pipe_pkg::P1 }: pd_legal = 1'b1;
         {pipe_pkg::P0,  pipe_pkg::P0S}: pd_legal = 1'b1;
         {pipe_pkg::P0S, pipe_pkg::P0 }: pd_legal = 1'b1;
         {pipe_pkg::P0,  pipe_pkg::P1 }: pd_legal = 1'b1;
         {pipe_pkg::P1,  pipe_pkg::P0 }: pd_legal = 1'b1;
         // Unchanged state or a transition with no handshake
         default:                        pd_legal = 1'b0;
      endcase
   end

   // ======================================
   // PhyStatus and RxStatus registers
   // ======================================

   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         plol_s1    <= 1'b1;
         plol_s2    <= 1'b1;
         pd_prev    <= pipe_pkg::P0;
         phy_status <= 1'b1;
         rx_status  <= pipe_pkg::RX_OK;
      end else begin
         plol_s1 <= pll_lol;
         plol_s2 <= plol_s1;
         pd_prev <= power_down;
         // Frozen until the PLL is seen locked
         if (!plol_s2) begin
            phy_status <= pd_legal | detect_done;
         end
         // Detect result overrides the PCS status for one cycle
         if (detect_done) begin
            rx_status <= rx_present ? pipe_pkg::RX_DETECTED : pipe_pkg::RX_OK;
         end else begin
            rx_status <= pcs_rx_status;
         end
      end
   end

   // Lock loss holds PhyStatus, including the reset-time high level
   a_hold_on_lol : assert property (@(posedge PCLK) disable iff (!RESET_n)
      plol_s2 |=> $stable(phy_status));

endmodule

//--- design/rx_detect_fsm.sv
// Receiver-detect sequencer, drives detect enable and charge time to the PCS
module rx_detect_fsm (
   input  logic                  PCLK,
   input  logic                  RESET_n,
   input  pipe_pkg::power_state_t power_down,
   input  logic                  tx_detect_rx,
   input  logic                  tx_elec_idle,
   input  logic                  pcie_done,
   input  logic                  pcie_con,
   output logic                  pcie_det_en,
   output logic                  pcie_ct,
   output logic                  detect_done,
   output logic                  rx_present
);

   // ======================================
   // Request and PCS status capture
   // ======================================

   // Request level, its delayed copy and the registered rising edge
   logic req_lvl;
   logic req_lvl_d;
   logic req_edge;

   // Bit 0 carries pcie_done, bit 1 carries pcie_con
   logic [1:0] pcs_s1;
   logic [1:0] pcs_s2;
   logic [1:0] pcs_d;
   logic [1:0] pcs_dd;
   logic       done_rise;

   phy_ctl_pkg::det_state_t            state;
   logic [phy_ctl_pkg::DET_CNT_W-1:0] det_cnt;

   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         req_lvl   <= 1'b0;
         req_lvl_d <= 1'b0;
         req_edge  <= 1'b0;
         pcs_s1    <= 2'b00;
         pcs_s2    <= 2'b00;
         pcs_d     <= 2'b00;
         pcs_dd    <= 2'b00;
         done_rise <= 1'b0;
      end else begin
         // Detect only asked in P1 with the transmitter idle
         req_lvl   <= (power_down == pipe_pkg::P1) & tx_detect_rx & tx_elec_idle;
         req_lvl_d <= req_lvl;
         req_edge  <= req_lvl & ~req_lvl_d;
         // Two-flop synchronizer for the PCS status pair
         pcs_s1    <= {pcie_con, pcie_done};
         pcs_s2    <= pcs_s1;
         // Edge register stage, con follows done so the pair stays aligned
         pcs_d     <= pcs_s2;
         pcs_dd    <= pcs_d;
         done_rise <= pcs_d[0] & ~pcs_dd[0];
      end
   end

   // ======================================
   // Detect state machine
   // ======================================

   always_ff @(posedge PCLK or negedge RESET_n) begin
      if (!RESET_n) begin
         state       <= phy_ctl_pkg::DET_IDLE;
         det_cnt     <= '0;
         pcie_det_en <= 1'b0;
         pcie_ct     <= 1'b0;
         detect_done <= 1'b0;
         rx_present  <= 1'b0;
      end else begin
         // Completion is a single-cycle pulse
         detect_done <= 1'b0;
         case (state)
            phy_ctl_pkg::DET_IDLE: begin
               det_cnt <= '0;
               if (req_edge) begin
                  state       <= phy_ctl_pkg::DET_EN;
                  pcie_det_en <= 1'b1;
               end
            end
            phy_ctl_pkg::DET_EN: begin
               det_cnt <= det_cnt + 1'b1;
               // Last enable cycle, counter restarts for charge time
               if (det_cnt == phy_ctl_pkg::DET_EN_CYCLES - 1'b1) begin
                  state   <= phy_ctl_pkg::DET_CT;
                  pcie_ct <= 1'b1;
                  det_cnt <= '0;
               end
            end
            phy_ctl_pkg::DET_CT: begin
               det_cnt <= det_cnt + 1'b1;
               if (det_cnt == phy_ctl_pkg::CT_CYCLES - 1'b1) begin
                  state   <= phy_ctl_pkg::DET_DONE;
                  pcie_ct <= 1'b0;
                  det_cnt <= '0;
               end
            end
            phy_ctl_pkg::DET_DONE: begin
               // Done edge ends the sequence and latches the result
               if (done_rise) begin
                  state       <= phy_ctl_pkg::DET_IDLE;
                  pcie_det_en <= 1'b0;
                  detect_done <= 1'b1;
                  rx_present  <= pcs_dd[1];
               end
            end
         endcase
      end
   end

   // ======================================
   // Checks
   // ======================================

   // Charge time only inside an enabled detect window
   a_ct_in_det_en : assert property (@(posedge PCLK) disable iff (!RESET_n)
      pcie_ct |-> pcie_det_en);

   // Charge time never leaks outside its own state
   a_ct_state : assert property (@(posedge PCLK) disable iff (!RESET_n)
      pcie_ct |-> (state == phy_ctl_pkg::DET_CT));

   // Completion seen by PhyStatus as one pulse
   a_done_pulse : assert property (@(posedge PCLK) disable iff (!RESET_n)
      detect_done |=> !detect_done);

endmodule

//--- design/phy_ctl_pkg.sv
// Internal sequencing types and timing counts for the PHY control logic
package phy_ctl_pkg;

   // ======================================
   // Receiver-detect FSM
   // ======================================

   // Detect sequence states
   typedef enum logic [1:0] {
      // Waiting for a MAC request
      DET_IDLE = 2'b00,
      // Detect enable on, timing the settle phase
      DET_EN   = 2'b01,
      // Charge-time pulse to the PCS
      DET_CT   = 2'b10,
      // Waiting for the PCS done edge
      DET_DONE = 2'b11
   } det_state_t;

   // Phase counter width
   localparam int DET_CNT_W = 9;

   // Detect enable before charge time, about 1 us at 250 MHz
   localparam logic [DET_CNT_W-1:0] DET_EN_CYCLES = 256;

   // Charge-time pulse length
   localparam logic [DET_CNT_W-1:0] CT_CYCLES = 6;

   // ======================================
   // RxValid qualification
   // ======================================

   // Ready counter width
   localparam int RDY_CNT_W = 10;

   // Stable receive cycles before RxValid is passed
   localparam logic [RDY_CNT_W-1:0] RDY_COUNT = 1000;

endpackage

//--- design/pipe_pkg.sv
// PIPE-side encodings shared by the PHY control blocks and the testbench
package pipe_pkg;

   // ======================================
   // Data widths
   // ======================================

   // RxStatus field width on the PIPE
   localparam int RX_STATUS_W = 3;

   // ======================================
   // Power states
   // ======================================

   // PowerDown encoding driven by the MAC
   typedef enum logic [1:0] {
      P0  = 2'b00,
      P0S = 2'b01,
      P1  = 2'b10,
      P2  = 2'b11
   } power_state_t;

   // ======================================
   // Receive status codes
   // ======================================

   // Only the codes the control logic produces itself
   // Other PCS codes travel as raw values
   typedef enum logic [RX_STATUS_W-1:0] {
      RX_OK       = 3'b000,
      RX_DETECTED = 3'b011
   } rx_status_t;

endpackage
